// ==== fir_adder_tree.sv ====
// registered pairwise adder tree
// reduces N_INPUTS terms to one wrapped sum in ceil(log2(N_INPUTS)) levels
// an odd leftover term rides a plain register to keep depths equal

`timescale 1ns/10ps

module fir_adder_tree #(
	parameter int N_INPUTS = 15
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     i_clk_ena,
	input  fir_types_pkg::sample_t [N_INPUTS-1:0]    i_terms,
	output fir_types_pkg::sample_t                   o_sum
);

	localparam int LEVELS = $clog2(N_INPUTS);

	// ******************************
	// tree levels
	// ******************************

	// level 0 is the raw input, level LEVELS holds the single sum
	for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
		// terms left after l halvings, rounded up
		localparam int CNT = (N_INPUTS + (1 << l) - 1) >> l;

		fir_types_pkg::sample_t node [CNT];

		if (l == 0) begin : g_in
			for (genvar i = 0; i < CNT; i++) begin : g_term
				assign node[i] = i_terms[i];
			end
		end else begin : g_reg
			// term count of the level below
			localparam int PREV = (N_INPUTS + (1 << (l - 1)) - 1) >> (l - 1);

			for (genvar i = 0; i < CNT; i++) begin : g_node
				if (2 * i + 1 < PREV) begin : g_add
					always_ff @(posedge clk or posedge reset) begin
						if (reset) begin
							node[i] <= '0;
						end else if (i_clk_ena) begin
							node[i] <= g_lvl[l-1].node[2*i] + g_lvl[l-1].node[2*i+1];
						end
					end
				end else begin : g_bye
					// unpaired term, delay only
					always_ff @(posedge clk or posedge reset) begin
						if (reset) begin
							node[i] <= '0;
						end else if (i_clk_ena) begin
							node[i] <= g_lvl[l-1].node[2*i];
						end
					end
				end
			end
		end
	end

	assign o_sum = g_lvl[LEVELS].node[0];

	// ******************************
	// checks
	// ******************************

	// products from the multiplier stage must be fully defined once running
	a_terms_known : assert property (
		@(posedge clk) disable iff (reset)
		i_clk_ena |-> !$isunknown(i_terms)
	) else $error("adder tree input has unknown bits");

endmodule

// ==== fir_coeff_pkg.sv ====
// filter geometry and coefficient table for the 30-tap symmetric FIR
// pipeline depth figures are derived from the tap count

package fir_coeff_pkg;

	// ******************************
	// geometry
	// ******************************

	localparam int N_TAPS = 30;

	// symmetric taps, so only half the coefficients are unique
	localparam int N_UNIQ = N_TAPS / 2;

	// registered adder levels needed to reduce N_UNIQ products
	localparam int TREE_LEVELS = $clog2(N_UNIQ);

	// tap register, pre-add, multiply, then the tree
	localparam int FIR_LATENCY = 3 + TREE_LEVELS;

	// ******************************
	// coefficients
	// ******************************

	// entry k weights taps k and N_TAPS-1-k
	localparam fir_types_pkg::coeff_t COEFFS [N_UNIQ] = '{
		18'd88,
		18'd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'd0,
		18'sd212
	};

endpackage

// ==== fir_filter.f ====
fir_types_pkg.sv
fir_coeff_pkg.sv
fir_tap_line.sv
fir_fold_mult.sv
fir_adder_tree.sv
fir_valid_delay.sv
fir_filter.sv
tb_fir_filter.sv

// ==== fir_filter.sv ====
// 30-tap symmetric FIR filter, top level
// delay line, folded multiply and adder tree, with a matching valid delay
// i_clk_ena stalls every stage together

`timescale 1ns/10ps

module fir_filter (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_clk_ena,
	input  logic                   i_valid,
	input  fir_types_pkg::sample_t i_in,
	output logic                   o_valid,
	output fir_types_pkg::sample_t o_out
);

	// ******************************
	// datapath
	// ******************************

	// newest sample at index 0
	fir_types_pkg::sample_t [fir_coeff_pkg::N_TAPS-1:0] taps;

	// one weighted mirror pair per entry
	fir_types_pkg::sample_t [fir_coeff_pkg::N_UNIQ-1:0] products;

	fir_tap_line #(
		.N_TAPS (fir_coeff_pkg::N_TAPS)
	) u_tap_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.o_taps    (taps)
	);

	fir_fold_mult #(
		.N_UNIQ (fir_coeff_pkg::N_UNIQ)
	) u_fold_mult (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.o_products (products)
	);

	fir_adder_tree #(
		.N_INPUTS (fir_coeff_pkg::N_UNIQ)
	) u_adder_tree (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_terms   (products),
		.o_sum     (o_out)
	);

	// ******************************
	// valid alignment
	// ******************************

	// depth equals the full datapath latency
	fir_valid_delay #(
		.DEPTH (fir_coeff_pkg::FIR_LATENCY)
	) u_valid_delay (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

// ==== fir_fold_mult.sv ====
// folding pre-adders and coefficient multipliers
// mirror taps are summed first, then weighted by their shared coefficient
// two register stages, all arithmetic wraps to one sample word

`timescale 1ns/10ps

module fir_fold_mult #(
	parameter int N_UNIQ = 15
) (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   i_clk_ena,
	input  fir_types_pkg::sample_t [2*N_UNIQ-1:0]  i_taps,
	output fir_types_pkg::sample_t [N_UNIQ-1:0]    o_products
);

	// ******************************
	// stage 1: symmetric pre-add
	// ******************************

	fir_types_pkg::sample_t [N_UNIQ-1:0] fold_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fold_q <= '0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < N_UNIQ; k++) begin
				// tap k pairs with its mirror at the far end
				fold_q[k] <= i_taps[k] + i_taps[2*N_UNIQ-1-k];
			end
		end
	end

	// ******************************
	// stage 2: coefficient multiply
	// ******************************

	fir_types_pkg::sample_t [N_UNIQ-1:0] prod_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prod_q <= '0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < N_UNIQ; k++) begin
				// low word of the product, same for signed and unsigned
				prod_q[k] <= fold_q[k] * fir_coeff_pkg::COEFFS[k];
			end
		end
	end

	assign o_products = prod_q;

endmodule

// ==== fir_tap_line.sv ====
// input delay line of the FIR filter
// holds the last N_TAPS samples, newest at index 0

`timescale 1ns/10ps

module fir_tap_line #(
	parameter int N_TAPS = 30
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 i_clk_ena,
	input  fir_types_pkg::sample_t               i_in,
	output fir_types_pkg::sample_t [N_TAPS-1:0]  o_taps
);

	// ******************************
	// sample shift register
	// ******************************

	fir_types_pkg::sample_t [N_TAPS-1:0] taps_q;

	// advances on every enabled edge, valid or not
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			taps_q <= '0;
		end else if (i_clk_ena) begin
			// oldest sample falls off the top end
			taps_q <= {taps_q[N_TAPS-2:0], i_in};
		end
	end

	// tap k is the sample from k enabled edges ago
	assign o_taps = taps_q;

endmodule

// ==== fir_types_pkg.sv ====
// datapath types for the symmetric FIR filter
// one word width for samples, coefficients, sums and products

package fir_types_pkg;

	// ******************************
	// widths
	// ******************************

	// samples and every intermediate value share one width
	// sums and products wrap modulo 2^SAMPLE_W
	localparam int SAMPLE_W = 18;

	// ******************************
	// word types
	// ******************************

	// signed sample or any wrapped intermediate value
	typedef logic [SAMPLE_W-1:0] sample_t;

	// fixed filter coefficient, two's complement
	typedef logic [SAMPLE_W-1:0] coeff_t;

endpackage

// ==== fir_valid_delay.sv ====
// valid strobe delay line
// shifts i_valid by DEPTH enabled edges to line up with the filter output

`timescale 1ns/10ps

module fir_valid_delay #(
	parameter int DEPTH = 7
) (
	input  logic clk,
	input  logic reset,
	input  logic i_clk_ena,
	input  logic i_valid,
	output logic o_valid
);

	logic [DEPTH-1:0] valid_q;

	// same enable as the datapath so both stall in lockstep
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[DEPTH-2:0], i_valid};
		end
	end

	assign o_valid = valid_q[DEPTH-1];

	// ******************************
	// checks
	// ******************************

	// a stalled edge must leave the output strobe untouched
	a_stall_holds : assert property (
		@(posedge clk) disable iff (reset)
		(!$past(i_clk_ena) && !$past(reset)) |-> $stable(o_valid)
	) else $error("o_valid changed across a stalled cycle");

endmodule

// ==== tb_fir_filter.sv ====
// testbench for the 30-tap symmetric FIR filter
// random samples and stalls checked against a tap-history model

`timescale 1ns/10ps

module tb_fir_filter;

	localparam int N_TAPS = fir_coeff_pkg::N_TAPS;
	localparam int LATENCY = fir_coeff_pkg::FIR_LATENCY;
	localparam int SW = fir_types_pkg::SAMPLE_W;
	localparam logic [31:0] SEED = 32'h49895334;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 10;
	localparam int N_STREAM = 400;
	localparam int N_STALL = 400;
	localparam int N_AFTER = 200;
	localparam int WAIT_LIMIT = 100;

	logic                   clk;
	logic                   reset;
	logic                   i_clk_ena;
	logic                   i_valid;
	fir_types_pkg::sample_t i_in;
	logic                   o_valid;
	fir_types_pkg::sample_t o_out;

	fir_filter uut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	// ******************************
	// model state
	// ******************************

	logic [31:0]            rand_state;
	fir_types_pkg::sample_t hist [N_TAPS];
	// each entry is {valid, sum}
	logic [SW:0]            exp_q [$];
	logic [SW:0]            exp_cur;
	fir_types_pkg::sample_t prev_out;
	logic                   prev_valid;
	int                     n_checks;
	int                     n_errors;
	int                     n_timeouts;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	// weight of tap j, mirrored about the centre
	function automatic fir_types_pkg::coeff_t tap_coeff(input int j);
		int k;
		k = (j < N_TAPS - 1 - j) ? j : N_TAPS - 1 - j;
		return fir_coeff_pkg::COEFFS[k];
	endfunction

	// direct-form sum over the history, wrapped to one word
	function automatic fir_types_pkg::sample_t model_sum();
		fir_types_pkg::sample_t acc;
		logic [2*SW-1:0]        prod;
		acc = '0;
		for (int j = 0; j < N_TAPS; j++) begin
			prod = tap_coeff(j) * hist[j];
			acc = acc + prod[SW-1:0];
		end
		return acc;
	endfunction

	task automatic model_reset();
		for (int j = 0; j < N_TAPS; j++) begin
			hist[j] = '0;
		end
		exp_q.delete();
		// pipeline registers hold the sum of an all-zero history
		for (int i = 0; i < LATENCY - 1; i++) begin
			exp_q.push_back('0);
		end
		exp_cur = '0;
	endtask

	task automatic model_advance(input logic valid, input fir_types_pkg::sample_t data);
		for (int j = N_TAPS - 1; j > 0; j--) begin
			hist[j] = hist[j-1];
		end
		hist[0] = data;
		exp_q.push_back({valid, model_sum()});
		exp_cur = exp_q.pop_front();
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ******************************
	// one clock with checks
	// ******************************

	task automatic clock_cycle();
		logic                   ena;
		logic                   valid;
		fir_types_pkg::sample_t data;
		ena = i_clk_ena;
		valid = i_valid;
		data = i_in;
		@(posedge clk);
		#DRIVE_DELAY;
		if (reset) begin
			check_value(o_valid, 0, "o_valid during reset");
			check_value(o_out, 0, "o_out during reset");
		end else begin
			if (ena) begin
				model_advance(valid, data);
			end else begin
				check_value(o_out, prev_out, "o_out held across stall");
				check_value(o_valid, prev_valid, "o_valid held across stall");
			end
			check_value(o_out, exp_cur[SW-1:0], "o_out against model");
			check_value(o_valid, exp_cur[SW], "o_valid against model");
		end
		prev_out = o_out;
		prev_valid = o_valid;
	endtask

	task automatic drive_random(input bit stall);
		logic [31:0] r_ctl;
		logic [31:0] r_data;
		r_ctl = next_random();
		r_data = next_random();
		// with stalls, enable is low about a third of the time
		i_clk_ena = stall ? (r_ctl % 3 != 0) : 1'b1;
		i_valid = r_ctl[16];
		i_in = r_data[SW-1:0];
	endtask

	task automatic run_impulse();
		int waited;
		i_clk_ena = 1'b1;
		i_valid = 1'b1;
		i_in = 18'd1;
		clock_cycle();
		i_valid = 1'b0;
		i_in = '0;
		waited = 0;
		while (o_valid !== 1'b1 && waited < WAIT_LIMIT) begin
			clock_cycle();
			waited++;
		end
		if (o_valid !== 1'b1) begin
			n_timeouts++;
			$display("timeout: o_valid never went high after the impulse");
		end else begin
			// coefficients appear in mirror order, one per cycle
			for (int j = 0; j < N_TAPS; j++) begin
				check_value(o_out, tap_coeff(j), "impulse response");
				clock_cycle();
			end
		end
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		n_checks = 0;
		n_errors = 0;
		n_timeouts = 0;
		rand_state = SEED;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		prev_out = '0;
		prev_valid = 1'b0;
		model_reset();

		repeat (RESET_CYCLES) begin
			clock_cycle();
		end
		reset = 1'b0;
		i_clk_ena = 1'b1;
		repeat (4) begin
			clock_cycle();
		end

		run_impulse();

		repeat (N_STREAM) begin
			drive_random(1'b0);
			clock_cycle();
		end

		repeat (N_STALL) begin
			drive_random(1'b1);
			clock_cycle();
		end

		// a full pipeline of valid samples, so o_valid is high going into reset
		repeat (LATENCY) begin
			drive_random(1'b0);
			i_valid = 1'b1;
			clock_cycle();
		end

		// asynchronous reset in the middle of traffic
		reset = 1'b1;
		#DRIVE_DELAY;
		check_value(o_valid, 0, "o_valid right after mid-stream reset");
		check_value(o_out, 0, "o_out right after mid-stream reset");
		model_reset();
		prev_out = '0;
		prev_valid = 1'b0;
		repeat (3) begin
			drive_random(1'b1);
			clock_cycle();
		end
		reset = 1'b0;
		repeat (N_AFTER) begin
			drive_random(1'b1);
			clock_cycle();
		end

		$display("checks %0d, value errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
